// ==== compile.f ====
+incdir+rtl
rtl/sdram_pkg.sv
rtl/host_port.sv
rtl/init_sequencer.sv
rtl/slot_scheduler.sv
rtl/sdram_cmd_out.sv
rtl/read_return.sv
rtl/sdram_ctrl_top.sv
sim/sdram_model.sv
sim/tb_sdram_ctrl.sv

// ==== sim/tb_sdram_ctrl.sv ====
`timescale 1ns/1ps
`include "sdram_params.svh"

module tb_sdram_ctrl import sdram_pkg::*; ();

	localparam int POOL        = 16;  // addresses used by the traffic
	localparam int WAIT_MAX    = 64;
	localparam int IDLE_FRAMES = 4;
	localparam int RAND_OPS    = 200;

	logic                   clk = 1'b0;
	logic                   reset;
	logic                   req;
	host_req_t              request;
	logic                   ack;
	logic [`SDRAM_DQ_W-1:0] rdata;
	sdram_pins_t            pins;
	logic [`SDRAM_DQ_W-1:0] dq_out;
	logic                   dq_oe;
	logic [`SDRAM_DQ_W-1:0] dq_in;
	logic                   model_err;

	host_req_t              pool [POOL];
	logic [`SDRAM_DQ_W-1:0] shadow [POOL];
	int                     req_count;
	int                     ack_count;
	logic                   ack_q;
	logic                   req_q;

	always #20 clk = ~clk;

	sdram_ctrl_top u_sdram_ctrl_top (
		.clk     (clk),
		.reset   (reset),
		.req     (req),
		.request (request),
		.ack     (ack),
		.rdata   (rdata),
		.pins    (pins),
		.dq_out  (dq_out),
		.dq_oe   (dq_oe),
		.dq_in   (dq_in)
	);

	sdram_model u_sdram_model (
		.clk    (clk),
		.pins   (pins),
		.dq_out (dq_out),
		.dq_oe  (dq_oe),
		.dq_in  (dq_in),
		.err    (model_err)
	);

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timed out at %0t waiting for %s", $time, what);
		$display("TEST RESULT: FAIL");
		$fatal(1, "timeout");
	endtask

	function automatic logic [`SDRAM_DQ_W-1:0] merge_bytes(input logic [`SDRAM_DQ_W-1:0] old_w,
			input logic [`SDRAM_DQ_W-1:0] new_w, input logic [`SDRAM_DQ_W/8-1:0] be);
		logic [`SDRAM_DQ_W-1:0] m;
		m = old_w;
		for (int i = 0; i < `SDRAM_DQ_W / 8; i++)
			if (be[i])
				m[8*i +: 8] = new_w[8*i +: 8];
		return m;
	endfunction

	// one full req/ack handshake against pool entry idx
	task automatic host_access(input int idx, input logic we, input logic [`SDRAM_DQ_W-1:0] wdata,
			input logic [`SDRAM_DQ_W/8-1:0] be);
		int                     n;
		host_req_t              r;
		logic [`SDRAM_DQ_W-1:0] got;
		r       = pool[idx];
		r.we    = we;
		r.wdata = wdata;
		r.be    = be;
		@(posedge clk);
		#1;
		request = r;
		req     = 1'b1;
		req_count++;
		n = 0;
		@(posedge clk);
		while (ack !== 1'b1) begin
			n++;
			if (n > WAIT_MAX)
				report_timeout("ack to rise");
			@(posedge clk);
		end
		got = rdata;  // valid while ack is high
		#1;
		req = 1'b0;
		n   = 0;
		@(posedge clk);
		while (ack !== 1'b0) begin
			n++;
			if (n > WAIT_MAX)
				report_timeout("ack to fall");
			@(posedge clk);
		end
		if (we)
			shadow[idx] = merge_bytes(shadow[idx], wdata, be);
		else
			check_eq(got, shadow[idx], "read data");
		check_eq(ack_count, req_count, "acks per request");
	endtask

	// handshake rules, command addresses and model protocol flag
	always @(posedge clk) begin
		sdram_cmd_e pin_cmd;
		if (reset) begin
			ack_q = 1'b0;
			req_q = 1'b0;
		end else begin
			if (ack && !ack_q) begin
				ack_count++;
				check_eq(req, 1'b1, "req at ack rise");
			end
			if (!ack && ack_q)
				check_eq(req_q, 1'b0, "req before ack fall");
			if (pins.cs_n === 1'b0) begin
				pin_cmd = sdram_cmd_e'({pins.ras_n, pins.cas_n, pins.we_n});
				if (pin_cmd == CMD_ACTIVE) begin
					check_eq(pins.bank, request.bank, "ACTIVE bank");
					check_eq(pins.addr[`SDRAM_ROW_W-1:0], request.row, "ACTIVE row");
				end else if (pin_cmd == CMD_READ || pin_cmd == CMD_WRITE) begin
					check_eq(pin_cmd, request.we ? CMD_WRITE : CMD_READ, "column command");
					check_eq(pins.bank, request.bank, "column bank");
					check_eq(pins.addr[`SDRAM_COL_W-1:0], request.col, "column address");
				end
			end
			ack_q = ack;
			req_q = req;
		end
		check_eq(model_err, 1'b0, "SDRAM protocol flag");
	end

	initial begin
		logic [31:0] seed;
		logic [31:0] rnd;
		int          seen;
		int          gap;
		int          frame;
		sdram_cmd_e  cmd;
		$timeformat(-9, 0, " ns", 0);
		seed      = $urandom(20);
		reset     = 1'b1;
		req       = 1'b0;
		request   = '0;
		req_count = 0;
		ack_count = 0;
		for (int i = 0; i < 16; i++) begin
			@(posedge clk);
			#1;
			check_eq(pins.cs_n, 1'b1, "cs_n in reset");
			check_eq(ack, 1'b0, "ack in reset");
		end
		reset = 1'b0;

		// init commands, then idle frames that must refresh
		seen = 0;
		gap  = 0;
		while (seen < `SDRAM_INIT_FRAMES + IDLE_FRAMES) begin
			@(posedge clk);
			gap++;
			if (pins.cs_n === 1'b0) begin
				frame = `SDRAM_INIT_FRAMES - 1 - seen;
				cmd   = sdram_cmd_e'({pins.ras_n, pins.cas_n, pins.we_n});
				if (frame == `SDRAM_PRE_FRAME) begin
					check_eq(cmd, CMD_PRECHARGE, "init precharge");
					check_eq(pins.addr[10], 1'b1, "precharge A10");
				end else if (frame == `SDRAM_LDM_FRAME) begin
					check_eq(cmd, CMD_LOAD_MODE, "init load-mode");
					check_eq(pins.addr, `SDRAM_MODE_WORD, "mode word");
				end else begin
					check_eq(cmd, CMD_REFRESH, "refresh");
				end
				if (seen > 0)
					check_eq(gap, `SDRAM_SLOTS, "command spacing");
				gap = 0;
				seen++;
			end else if (gap > 2 * `SDRAM_SLOTS) begin
				report_timeout("init or refresh command");
			end
		end

		for (int i = 0; i < POOL; i++) begin
			rnd          = $urandom;
			pool[i]      = '0;
			pool[i].bank = rnd[`SDRAM_BANK_W-1:0];
			pool[i].row  = rnd[16 +: `SDRAM_ROW_W];
			pool[i].col  = {rnd[11:8], 4'(i)};  // low bits keep entries distinct
		end
		for (int i = 0; i < POOL; i++) begin
			rnd = $urandom;
			host_access(i, 1'b1, rnd[15:0], 2'b11);
		end

		host_access(0, 1'b1, 16'h5aa5, 2'b11);
		host_access(0, 1'b0, '0, 2'b11);
		host_access(1, 1'b1, 16'hc3e1, 2'b01);  // low byte only
		host_access(1, 1'b0, '0, 2'b11);
		host_access(1, 1'b1, 16'h7f08, 2'b10);
		host_access(1, 1'b0, '0, 2'b11);

		for (int i = 0; i < RAND_OPS; i++) begin
			rnd = $urandom;
			host_access(int'(rnd[3:0]), rnd[4], rnd[31:16], rnd[6:5]);
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== sim/sdram_model.sv ====
`timescale 1ns/1ps
`include "sdram_params.svh"

module sdram_model import sdram_pkg::*; (
	input  logic                   clk,
	input  sdram_pins_t            pins,
	input  logic [`SDRAM_DQ_W-1:0] dq_out,
	input  logic                   dq_oe,
	output logic [`SDRAM_DQ_W-1:0] dq_in,
	output logic                   err
);

	localparam int NBANK  = 1 << `SDRAM_BANK_W;
	localparam int ADDR_W = `SDRAM_BANK_W + `SDRAM_ROW_W + `SDRAM_COL_W;

	logic [`SDRAM_DQ_W-1:0]  mem [0:(1 << ADDR_W) - 1];
	logic [`SDRAM_ROW_W-1:0] open_row [NBANK];
	logic                    is_open [NBANK];
	int                      act_cyc [NBANK];
	logic [`SDRAM_DQ_W-1:0]  rd_pipe [`SDRAM_CAS_LAT-1];  // last stage feeds dq_in
	logic                    mode_set;
	int                      cyc;

	task report_violation(input string msg);
		$display("sdram model at %0t: %s", $time, msg);
		err <= 1'b1;
	endtask

	initial begin
		err      = 1'b0;
		dq_in    = '0;
		mode_set = 1'b0;
		cyc      = 0;
		for (int b = 0; b < NBANK; b++)
			is_open[b] = 1'b0;
	end

	always @(posedge clk) begin
		logic [`SDRAM_BANK_W-1:0] b;
		logic [ADDR_W-1:0]        idx;
		cyc = cyc + 1;
		dq_in <= rd_pipe[`SDRAM_CAS_LAT-2];
		for (int i = `SDRAM_CAS_LAT - 2; i > 0; i--)
			rd_pipe[i] <= rd_pipe[i-1];
		rd_pipe[0] <= 'x;  // no read this cycle
		if (pins.cs_n === 1'b0) begin
			b = pins.bank;
			case (sdram_cmd_e'({pins.ras_n, pins.cas_n, pins.we_n}))
				CMD_ACTIVE: begin
					if (!mode_set)
						report_violation("ACTIVE issued before the load-mode command");
					if (is_open[b])
						report_violation("ACTIVE to a bank that already has an open row");
					is_open[b]  = 1'b1;
					open_row[b] = pins.addr[`SDRAM_ROW_W-1:0];
					act_cyc[b]  = cyc;
				end
				CMD_READ, CMD_WRITE: begin
					if (!is_open[b])
						report_violation("column access to a bank with no open row");
					if (cyc - act_cyc[b] < `SDRAM_RCD)
						report_violation("column access too soon after ACTIVE (tRCD)");
					if (!pins.addr[10])
						report_violation("column access without auto-precharge");
					idx = {b, open_row[b], pins.addr[`SDRAM_COL_W-1:0]};
					if (pins.we_n) begin
						rd_pipe[0] <= mem[idx];
					end else begin
						if (!dq_oe)
							report_violation("WRITE without data driven on the bus");
						for (int i = 0; i < `SDRAM_DQ_W / 8; i++)
							if (!pins.dqm[i])
								mem[idx][8*i +: 8] = dq_out[8*i +: 8];
					end
					is_open[b] = 1'b0;  // auto-precharge
				end
				CMD_PRECHARGE: begin
					for (int i = 0; i < NBANK; i++)
						if (pins.addr[10] || i == b)
							is_open[i] = 1'b0;
				end
				CMD_REFRESH: begin
					for (int i = 0; i < NBANK; i++)
						if (is_open[i])
							report_violation("REFRESH while a bank is open");
				end
				CMD_LOAD_MODE: mode_set = 1'b1;
				default: ;
			endcase
		end
		if (dq_oe === 1'b1 && (pins.cs_n !== 1'b0
				|| {pins.ras_n, pins.cas_n, pins.we_n} != CMD_WRITE))
			report_violation("data driven on the bus outside a WRITE");
	end

endmodule

// ==== rtl/sdram_ctrl_top.sv ====
`timescale 1ns/1ps
`include "sdram_params.svh"

module sdram_ctrl_top import sdram_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   req,
	input  host_req_t              request,
	output logic                   ack,
	output logic [`SDRAM_DQ_W-1:0] rdata,
	output sdram_pins_t            pins,
	output logic [`SDRAM_DQ_W-1:0] dq_out,
	output logic                   dq_oe,
	input  logic [`SDRAM_DQ_W-1:0] dq_in
);

	logic       pending;
	logic       take;
	logic       wr_done;  // from the WRITE slot
	logic       rd_done;  // from the read capture
	logic       frame_end;
	logic       init_done;
	host_req_t  held;
	init_step_e init_step;
	slot_op_t   op;

	host_port u_host_port (
		.clk     (clk),
		.reset   (reset),
		.req     (req),
		.request (request),
		.take    (take),
		.done    (wr_done | rd_done),
		.pending (pending),
		.held    (held),
		.ack     (ack)
	);

	init_sequencer u_init_sequencer (
		.clk       (clk),
		.reset     (reset),
		.frame_end (frame_end),
		.init_step (init_step),
		.init_done (init_done)
	);

	slot_scheduler u_slot_scheduler (
		.clk       (clk),
		.reset     (reset),
		.init_step (init_step),
		.init_done (init_done),
		.pending   (pending),
		.held      (held),
		.take      (take),
		.done      (wr_done),
		.frame_end (frame_end),
		.op        (op)
	);

	sdram_cmd_out u_sdram_cmd_out (
		.clk    (clk),
		.reset  (reset),
		.op     (op),
		.pins   (pins),
		.dq_out (dq_out),
		.dq_oe  (dq_oe)
	);

	read_return u_read_return (
		.clk      (clk),
		.reset    (reset),
		.read_tag (op.read_tag),
		.dq_in    (dq_in),
		.rdata    (rdata),
		.done     (rd_done)
	);

endmodule

// ==== rtl/read_return.sv ====
`timescale 1ns/1ps
`include "sdram_params.svh"

module read_return (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   read_tag,
	input  logic [`SDRAM_DQ_W-1:0] dq_in,
	output logic [`SDRAM_DQ_W-1:0] rdata,
	output logic                   done
);

	// stage 0 lines up with the READ on the pins
	logic [`SDRAM_CAS_LAT:0] tag_line;

	always_ff @(posedge clk) begin
		if (reset)
			tag_line <= '0;
		else
			tag_line <= {tag_line[`SDRAM_CAS_LAT-1:0], read_tag};
	end

	always_ff @(posedge clk) begin
		if (tag_line[`SDRAM_CAS_LAT])
			rdata <= dq_in;  // data valid this cycle
	end

	assign done = tag_line[`SDRAM_CAS_LAT];

endmodule

// ==== rtl/sdram_cmd_out.sv ====
`timescale 1ns/1ps
`include "sdram_params.svh"

module sdram_cmd_out import sdram_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	input  slot_op_t               op,
	output sdram_pins_t            pins,
	output logic [`SDRAM_DQ_W-1:0] dq_out,
	output logic                   dq_oe
);

	localparam int AP_BIT = 10;

	logic [`SDRAM_A_W-1:0] addr_next;
	logic                  is_write;

	assign is_write = (op.cmd == CMD_WRITE);

	always_comb begin
		addr_next = '0;
		case (op.cmd)
			CMD_ACTIVE:
				addr_next[`SDRAM_ROW_W-1:0] = op.row;
			CMD_READ, CMD_WRITE: begin
				addr_next[`SDRAM_COL_W-1:0] = op.col;
				addr_next[AP_BIT]           = op.ap;
			end
			CMD_LOAD_MODE:
				addr_next = `SDRAM_MODE_WORD;
			CMD_PRECHARGE:
				addr_next[AP_BIT] = op.ap;
			default:
				addr_next = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pins.cs_n  <= 1'b1;
			pins.ras_n <= 1'b1;
			pins.cas_n <= 1'b1;
			pins.we_n  <= 1'b1;
			dq_oe      <= 1'b0;
		end else begin
			pins.cs_n <= (op.cmd == CMD_NOP);  // deselect when idle
			{pins.ras_n, pins.cas_n, pins.we_n} <= op.cmd;
			dq_oe <= is_write;
		end
		pins.bank <= op.bank;
		pins.addr <= addr_next;
		pins.dqm  <= is_write ? ~op.be : '0;  // reads never masked
		dq_out    <= op.wdata;
	end

endmodule

// ==== rtl/slot_scheduler.sv ====
`timescale 1ns/1ps
`include "sdram_params.svh"

module slot_scheduler import sdram_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  init_step_e init_step,
	input  logic       init_done,
	input  logic       pending,
	input  host_req_t  held,
	output logic       take,
	output logic       done,
	output logic       frame_end,
	output slot_op_t   op
);

	localparam int SLOT_W = $clog2(`SDRAM_SLOTS);

	localparam logic [SLOT_W-1:0] ACT_SLOT  = '0;
	localparam logic [SLOT_W-1:0] CAS_SLOT  = SLOT_W'(`SDRAM_RCD + 1);
	localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(`SDRAM_SLOTS - 1);

	logic [SLOT_W-1:0] slot;
	logic              inflight;  // request owns this frame
	host_req_t         cur;

	assign frame_end = (slot == LAST_SLOT);
	assign take      = frame_end && pending && init_done;
	assign done      = init_done && inflight && cur.we && (slot == CAS_SLOT);

	always_ff @(posedge clk) begin
		if (reset) begin
			slot     <= '0;
			inflight <= 1'b0;
		end else begin
			slot <= frame_end ? '0 : slot + 1'b1;
			if (take)
				inflight <= 1'b1;
			else if (slot == CAS_SLOT)
				inflight <= 1'b0;  // auto-precharge closes the row
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			cur <= held;
	end

	always_comb begin
		op     = '0;
		op.cmd = CMD_NOP;
		if (!init_done) begin
			if (slot == ACT_SLOT) begin
				case (init_step)
					STEP_PRECHARGE: begin
						op.cmd = CMD_PRECHARGE;
						op.ap  = 1'b1;  // all banks
					end
					STEP_LOAD_MODE: op.cmd = CMD_LOAD_MODE;
					STEP_REFRESH:   op.cmd = CMD_REFRESH;
					default:        op.cmd = CMD_NOP;
				endcase
			end
		end else if (slot == ACT_SLOT) begin
			if (inflight) begin
				op.cmd  = CMD_ACTIVE;
				op.bank = cur.bank;
				op.row  = cur.row;
			end else begin
				op.cmd = CMD_REFRESH;  // idle frame
			end
		end else if (slot == CAS_SLOT && inflight) begin
			op.cmd      = cur.we ? CMD_WRITE : CMD_READ;
			op.bank     = cur.bank;
			op.col      = cur.col;
			op.ap       = 1'b1;
			op.wdata    = cur.wdata;
			op.be       = cur.be;
			op.read_tag = !cur.we;
		end
	end

endmodule

// ==== rtl/init_sequencer.sv ====
`timescale 1ns/1ps
`include "sdram_params.svh"

module init_sequencer import sdram_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       frame_end,
	output init_step_e init_step,
	output logic       init_done
);

	localparam int CNT_W = $clog2(`SDRAM_INIT_FRAMES);

	localparam logic [CNT_W-1:0] FIRST_FRAME = CNT_W'(`SDRAM_INIT_FRAMES - 1);
	localparam logic [CNT_W-1:0] PRE_FRAME   = CNT_W'(`SDRAM_PRE_FRAME);
	localparam logic [CNT_W-1:0] LDM_FRAME   = CNT_W'(`SDRAM_LDM_FRAME);

	logic [CNT_W-1:0] frame_cnt;  // counts down to 0

	always_ff @(posedge clk) begin
		if (reset) begin
			frame_cnt <= FIRST_FRAME;
			init_done <= 1'b0;
		end else if (frame_end && !init_done) begin
			if (frame_cnt == '0)
				init_done <= 1'b1;
			else
				frame_cnt <= frame_cnt - 1'b1;
		end
	end

	always_comb begin
		if (init_done)
			init_step = STEP_NORMAL;
		else if (frame_cnt == PRE_FRAME)
			init_step = STEP_PRECHARGE;
		else if (frame_cnt == LDM_FRAME)
			init_step = STEP_LOAD_MODE;
		else
			init_step = STEP_REFRESH;
	end

endmodule

// ==== rtl/host_port.sv ====
`timescale 1ns/1ps
`include "sdram_params.svh"

module host_port import sdram_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      req,
	input  host_req_t request,
	input  logic      take,
	input  logic      done,
	output logic      pending,
	output host_req_t held,
	output logic      ack
);

	logic busy;   // request latched, not yet released
	logic taken;  // scheduler owns it
	logic accept;

	assign accept = req && !busy;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy  <= 1'b0;
			taken <= 1'b0;
			ack   <= 1'b0;
		end else if (ack && !req) begin
			// host released req, close the handshake
			busy  <= 1'b0;
			taken <= 1'b0;
			ack   <= 1'b0;
		end else begin
			if (accept)
				busy <= 1'b1;
			if (take)
				taken <= 1'b1;
			if (done)
				ack <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			held <= request;
	end

	assign pending = busy && !taken && !ack;

endmodule

// ==== rtl/sdram_pkg.sv ====
`include "sdram_params.svh"

package sdram_pkg;

	// {ras_n, cas_n, we_n}
	typedef enum logic [2:0] {
		CMD_LOAD_MODE = 3'b000,
		CMD_REFRESH   = 3'b001,
		CMD_PRECHARGE = 3'b010,
		CMD_ACTIVE    = 3'b011,
		CMD_WRITE     = 3'b100,
		CMD_READ      = 3'b101,
		CMD_NOP       = 3'b111
	} sdram_cmd_e;

	typedef enum logic [1:0] {
		STEP_NORMAL    = 2'b00,
		STEP_REFRESH   = 2'b01,
		STEP_LOAD_MODE = 2'b10,
		STEP_PRECHARGE = 2'b11
	} init_step_e;

	typedef struct packed {
		logic                       we;     // 1 = write
		logic [`SDRAM_BANK_W-1:0]   bank;
		logic [`SDRAM_ROW_W-1:0]    row;
		logic [`SDRAM_COL_W-1:0]    col;
		logic [`SDRAM_DQ_W-1:0]     wdata;
		logic [`SDRAM_DQ_W/8-1:0]   be;
	} host_req_t;

	typedef struct packed {
		sdram_cmd_e                 cmd;
		logic [`SDRAM_BANK_W-1:0]   bank;
		logic [`SDRAM_ROW_W-1:0]    row;
		logic [`SDRAM_COL_W-1:0]    col;
		logic                       ap;       // auto-precharge / all banks
		logic [`SDRAM_DQ_W-1:0]     wdata;
		logic [`SDRAM_DQ_W/8-1:0]   be;
		logic                       read_tag;
	} slot_op_t;

	typedef struct packed {
		logic                       cs_n;
		logic                       ras_n;
		logic                       cas_n;
		logic                       we_n;
		logic [`SDRAM_BANK_W-1:0]   bank;
		logic [`SDRAM_A_W-1:0]      addr;
		logic [`SDRAM_DQ_W/8-1:0]   dqm;
	} sdram_pins_t;

endpackage

// ==== rtl/sdram_params.svh ====
`ifndef SDRAM_PARAMS_SVH
`define SDRAM_PARAMS_SVH

`define SDRAM_BANK_W       2
`define SDRAM_ROW_W        11
`define SDRAM_COL_W        8
`define SDRAM_A_W          13
`define SDRAM_DQ_W         16

`define SDRAM_CAS_LAT      3
`define SDRAM_RCD          2   // tRCD in clocks

`define SDRAM_SLOTS        8   // clocks per frame
`define SDRAM_INIT_FRAMES  16
`define SDRAM_PRE_FRAME    15
`define SDRAM_LDM_FRAME    4

// single writes, standard op, CL3, sequential, burst of 1
`define SDRAM_MODE_WORD    13'b000_1_00_011_0_000

`endif
